/* verif/cpu_tests.mem */
// columns: instr[31:16] ctrl[15:12] data[11:4] flags[3:0], flags as zero carry negative overflow
// ctrl bit0 means a result is expected, bit1 means issue with no gap after the previous word
30101008 // MOV R0,R1 after reset
33201008 // MOV R3,R2
31301008 // MOV R1,R3
32001008 // MOV R2,R0
10001008 // LDI R0,00
11801802 // LDI R1,80
127F17F0 // LDI R2,7F
13FF1FF2 // LDI R3,FF
7011100D // ADD R0=R1+R1 carry and overflow
70221FE3 // ADD R0=R2+R2 overflow
81231807 // SUB R1=R2-R3 borrow
82221008 // SUB R2=R2-R2
D330100C // INC R3 from FF
E2201FF6 // DEC R2 from 00
D1101812 // INC R1 from 80
90001FC6 // LSL R0 from FE
A1101404 // LSR R1 from 81
42211400 // AND R2=R2&R1
53301FC2 // OR R3=R3|R0
60301030 // NOT R0=~R3
00FF0000 // opcode 0
20550000 // opcode 2
B0AA0000 // opcode B
C0110000 // opcode C
F0FF0000 // opcode F
31001030 // MOV R1,R0 still 03
12011010 // LDI R2,01
72223020 // ADD R2=R2+R2 from one ahead
73223040 // ADD R3=R2+R2 from one ahead
70233060 // ADD R0=R2+R3 from one and two ahead
81033020 // SUB R1=R0-R3
13801802 // LDI R3,80
E33037F1 // DEC R3 overflow
D3303803 // INC R3 overflow

/* sim.f */
+incdir+design
design/cpuPkg.sv
design/decodeUnit.sv
design/executeUnit.sv
design/resultUnit.sv
design/cpuCore.sv
verif/cpuCore_tb.sv

/* Bender.yml */
package:
  name: cpu_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cpuPkg.sv
      - design/decodeUnit.sv
      - design/executeUnit.sv
      - design/resultUnit.sv
      - design/cpuCore.sv
  - target: test
    files:
      - verif/cpuCore_tb.sv

/* verif/cpuCore_tb.sv */
// reads verif/cpu_tests.mem from the project root; expects each legal word to retire three cycles after acceptance
`timescale 1ns/1ps

module cpuCore_tb;
    import cpuPkg::*;

    localparam int  MAX_TESTS    = 64;
    localparam int  RESET_CYCLES = 10;
    localparam int  LATENCY      = 3;    // acceptance edge to observed pulse
    localparam time PERIOD       = 40ns;

    // one line of the test file
    typedef struct packed {
        instr_t     instr;
        logic [3:0] ctrl;   // bit0 result expected, bit1 no gap before
        data_t      data;
        flags_t     flags;
    } testLine_t;

    typedef struct packed {
        regIdx_t     dest;
        data_t       data;
        flags_t      flags;
        logic [31:0] accepted;  // cycle of the sampling edge
    } expResult_t;

    logic        CLK = 1'b0;
    logic        reset_i;
    logic        instrValid_i;
    instr_t      instr_i;
    logic        resultValid_o;
    data_t       result_o;
    regIdx_t     resultDest_o;
    flags_t      flags_o;

    logic [31:0] testMem [0:MAX_TESTS-1];
    expResult_t  expQ [$];     // in issue order
    int          numTests;
    int          errors   = 0;
    int          expTotal = 0;
    int          seen     = 0; // every result pulse, expected or not
    logic [31:0] cycle    = 0;
    bit          loaded   = 1'b0;
    integer      seed;

    cpuCore UUT (
        .CLK           (CLK),
        .reset_i       (reset_i),
        .instrValid_i  (instrValid_i),
        .instr_i       (instr_i),
        .resultValid_o (resultValid_o),
        .result_o      (result_o),
        .resultDest_o  (resultDest_o),
        .flags_o       (flags_o)
    );

    always #(PERIOD / 2) CLK = ~CLK;

    always @(posedge CLK) cycle <= cycle + 1;

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got %0h, expected %0h (cycle %0d)", name, actual,
                     expected, cycle);
            errors++;
        end
    endtask

    task automatic checkResult();
        expResult_t head;
        seen++;
        if (expQ.size() == 0) begin
            $display("ERROR: result pulse at cycle %0d with no result expected", cycle);
            errors++;
        end else begin
            head = expQ.pop_front();
            compareValue("result_o", result_o, head.data);
            compareValue("resultDest_o", resultDest_o, head.dest);
            compareValue("flags_o", flags_o, head.flags);
            compareValue("latency", cycle - head.accepted, LATENCY);
        end
    endtask

    // outputs sampled at the edge, values settled since the previous one
    always @(posedge CLK) begin
        if (!reset_i && resultValid_o) checkResult();
    end

    initial begin
        testLine_t  entry;
        expResult_t item;
        int         gap;
        reset_i      = 1'b1;         // all inputs known from time 0
        instrValid_i = 1'b0;
        instr_i      = '0;
        seed         = 32'hd5c8;
        $readmemh("verif/cpu_tests.mem", testMem);
        numTests = 0;
        while (numTests < MAX_TESTS && !$isunknown(testMem[numTests])) numTests++;
        loaded = 1'b1;
        if (numTests == 0) begin
            $display("ERROR: no test lines could be read from the test file");
            errors++;
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        reset_i <= 1'b0;
        for (int i = 0; i < numTests; i++) begin
            entry = testLine_t'(testMem[i]);
            gap   = entry.ctrl[1] ? 0 : $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge CLK);
                instrValid_i <= 1'b0;    // idle slot
            end
            @(posedge CLK);
            instrValid_i <= 1'b1;
            instr_i      <= entry.instr;
            if (entry.ctrl[0]) begin
                item.dest     = entry.instr[9:8];  // destination field
                item.data     = entry.data;
                item.flags    = entry.flags;
                item.accepted = cycle + 1;         // sampled at the next edge
                expQ.push_back(item);
                expTotal++;
            end
        end
        @(posedge CLK);
        instrValid_i <= 1'b0;
        while (expQ.size() != 0) @(posedge CLK);
        repeat (LATENCY + 2) @(posedge CLK);   // catch stray pulses
        if (seen != expTotal) begin
            $display("ERROR: %0d result pulses seen but %0d results were expected",
                     seen, expTotal);
            errors++;
        end
        $display("errors: %0d, result pulses: %0d, results expected: %0d",
                 errors, seen, expTotal);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // four cycles per line covers the widest gaps plus the drain
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + 4 * numTests) @(posedge CLK);
        $display("ERROR: watchdog expired with %0d results still outstanding", expQ.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* design/cpuCore.sv */
// three-stage core with no back-pressure; every legal word retires exactly three cycles after acceptance
`timescale 1ns/1ps

module cpuCore (
    input  logic            CLK,
    input  logic            reset_i,
    input  logic            instrValid_i,     // one-cycle strobe per word
    input  cpuPkg::instr_t  instr_i,
    output logic            resultValid_o,
    output cpuPkg::data_t   result_o,
    output cpuPkg::regIdx_t resultDest_o,
    output cpuPkg::flags_t  flags_o
);
    import cpuPkg::*;

    decoded_t  decoded;   // decode -> execute
    exResult_t aluNow;    // execute -> decode, same cycle
    exResult_t exReg;     // execute -> result and decode
    regFile_t  regs;      // result -> decode

    decodeUnit decode (
        .CLK          (CLK),
        .reset_i      (reset_i),
        .instrValid_i (instrValid_i),
        .instr_i      (instr_i),
        .regs_i       (regs),
        .aluNow_i     (aluNow),
        .exReg_i      (exReg),
        .decoded_o    (decoded)
    );

    executeUnit execute (
        .CLK       (CLK),
        .reset_i   (reset_i),
        .decoded_i (decoded),
        .aluNow_o  (aluNow),
        .exReg_o   (exReg)
    );

    resultUnit result (
        .CLK           (CLK),
        .reset_i       (reset_i),
        .exReg_i       (exReg),
        .regs_o        (regs),
        .resultValid_o (resultValid_o),
        .result_o      (result_o),
        .resultDest_o  (resultDest_o),
        .flags_o       (flags_o)
    );

endmodule

/* design/resultUnit.sv */
// register file and flags clear on reset; result_o and resultDest_o only mean something while resultValid_o is high
`timescale 1ns/1ps

`include "cpu_config.svh"

module resultUnit (
    input  logic              CLK,
    input  logic              reset_i,
    input  cpuPkg::exResult_t exReg_i,
    output cpuPkg::regFile_t  regs_o,
    output logic              resultValid_o,
    output cpuPkg::data_t     result_o,
    output cpuPkg::regIdx_t   resultDest_o,
    output cpuPkg::flags_t    flags_o
);
    import cpuPkg::*;

    regFile_t                   regFile;
    logic [`CPU_FLAG_WIDTH-1:0] flagReg;  // last retired flags

    always_ff @(posedge CLK) begin
        if (reset_i) begin
            regFile       <= '0;
            flagReg       <= '0;
            resultValid_o <= 1'b0;
        end else begin
            resultValid_o <= exReg_i.valid;   // one pulse per result
            if (exReg_i.valid) begin
                regFile[exReg_i.dest] <= exReg_i.data;
                flagReg               <= exReg_i.flags;
            end
        end
    end

    // payload for the result port
    always_ff @(posedge CLK) begin
        if (exReg_i.valid) begin
            result_o     <= exReg_i.data;
            resultDest_o <= exReg_i.dest;
        end
    end

    assign regs_o  = regFile;            // decode reads the settled file
    assign flags_o = flags_t'(flagReg);

    // operands forwarded through decode and execute must be resolved by now
    assert property (@(posedge CLK) disable iff (reset_i)
        exReg_i.valid |-> !$isunknown({exReg_i.dest, exReg_i.data}))
        else $error("unknown data written to the register file");

endmodule

/* design/executeUnit.sv */
// single-cycle ALU; carry is the borrow on SUB and DEC, overflow is set for arithmetic ops only
`timescale 1ns/1ps

`include "cpu_config.svh"

module executeUnit (
    input  logic              CLK,
    input  logic              reset_i,
    input  cpuPkg::decoded_t  decoded_i,
    output cpuPkg::exResult_t aluNow_o,   // unregistered, for forwarding
    output cpuPkg::exResult_t exReg_o
);
    import cpuPkg::*;

    localparam int MSB = `CPU_DATA_WIDTH - 1;

    data_t                   opA;
    data_t                   opB;
    data_t                   res;
    logic [`CPU_DATA_WIDTH:0] wide;       // extra bit holds carry or borrow
    flags_t                  aluFlags;

    assign opA = decoded_i.operandA;
    assign opB = decoded_i.operandB;

    always_comb begin
        wide     = '0;
        res      = '0;
        aluFlags = '0;
        case (decoded_i.op)
            LDI: res = decoded_i.immediate;
            MOV: res = opA;
            AND: res = opA & opB;
            OR:  res = opA | opB;
            NOT: res = ~opA;
            ADD: begin
                wide              = {1'b0, opA} + {1'b0, opB};
                res               = wide[MSB:0];
                aluFlags.carry    = wide[`CPU_DATA_WIDTH];
                aluFlags.overflow = (opA[MSB] == opB[MSB]) && (res[MSB] != opA[MSB]);
            end
            SUB: begin
                wide              = {1'b0, opA} - {1'b0, opB};
                res               = wide[MSB:0];
                aluFlags.carry    = wide[`CPU_DATA_WIDTH];  // borrow
                aluFlags.overflow = (opA[MSB] != opB[MSB]) && (res[MSB] != opA[MSB]);
            end
            LSL: begin
                res            = opA << 1;
                aluFlags.carry = opA[MSB];   // bit shifted out
            end
            LSR: begin
                res            = opA >> 1;
                aluFlags.carry = opA[0];
            end
            INC: begin
                wide              = {1'b0, opA} + 1'b1;
                res               = wide[MSB:0];
                aluFlags.carry    = wide[`CPU_DATA_WIDTH]; // FF wraps
                aluFlags.overflow = !opA[MSB] && res[MSB]; // 7F -> 80
            end
            DEC: begin
                wide              = {1'b0, opA} - 1'b1;
                res               = wide[MSB:0];
                aluFlags.carry    = wide[`CPU_DATA_WIDTH]; // borrow from 00
                aluFlags.overflow = opA[MSB] && !res[MSB]; // 80 -> 7F
            end
            default: res = '0;
        endcase
        aluFlags.zero     = (res == '0);
        aluFlags.negative = res[MSB];
    end

    assign aluNow_o = '{valid: decoded_i.valid, dest: decoded_i.dest,
                        data: res, flags: aluFlags};

    always_ff @(posedge CLK) begin
        exReg_o <= aluNow_o;
        if (reset_i) begin
            exReg_o.valid <= 1'b0;
        end
    end

    // logic ops leave carry clear in the registered result
    assert property (@(posedge CLK) disable iff (reset_i)
        decoded_i.valid && decoded_i.op inside {MOV, AND, OR, NOT}
            |=> exReg_o.valid && !exReg_o.flags.carry)
        else $error("carry set by a logic operation");

endmodule

/* design/decodeUnit.sv */
// accepts one word per cycle with no stall; illegal opcodes are dropped here and never retire
`timescale 1ns/1ps

module decodeUnit (
    input  logic              CLK,
    input  logic              reset_i,
    input  logic              instrValid_i,
    input  cpuPkg::instr_t    instr_i,
    input  cpuPkg::regFile_t  regs_i,     // settled register file
    input  cpuPkg::exResult_t aluNow_i,   // op in execute right now
    input  cpuPkg::exResult_t exReg_i,    // op being written this edge
    output cpuPkg::decoded_t  decoded_o
);
    import cpuPkg::*;

    opcode_e  opcode;
    logic     legal;
    regIdx_t  srcA;
    regIdx_t  srcB;
    decoded_t decodedNext;

    // youngest producer wins, then the landing write, then the file
    function automatic data_t forward(
        input regIdx_t   idx,
        input exResult_t young,
        input exResult_t old,
        input regFile_t  regs
    );
        data_t value;
        if (young.valid && young.dest == idx) begin
            value = young.data;       // one instruction ahead
        end else if (old.valid && old.dest == idx) begin
            value = old.data;         // two ahead, write not visible yet
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    assign opcode = opcode_e'(instr_i[15:12]); // top nibble
    assign srcA   = instr_i[5:4];
    assign srcB   = instr_i[1:0];

    always_comb begin
        case (opcode)
            LDI, MOV, AND, OR, NOT, ADD, SUB, LSL, LSR, INC, DEC: begin
                legal = 1'b1;
            end
            default: begin
                legal = 1'b0;  // 0, 2, B, C, F
            end
        endcase
    end

    always_comb begin
        decodedNext.valid     = instrValid_i && legal;
        decodedNext.op        = opcode;
        decodedNext.dest      = instr_i[9:8];
        decodedNext.operandA  = forward(srcA, aluNow_i, exReg_i, regs_i);
        decodedNext.operandB  = forward(srcB, aluNow_i, exReg_i, regs_i);
        decodedNext.immediate = instr_i[7:0]; // only LDI reads it
    end

    always_ff @(posedge CLK) begin
        decoded_o <= decodedNext;      // payload every edge
        if (reset_i) begin
            decoded_o.valid <= 1'b0;
        end
    end

    // a valid slot only ever carries a legal opcode
    assert property (@(posedge CLK) disable iff (reset_i)
        decoded_o.valid |-> decoded_o.op inside
            {LDI, MOV, AND, OR, NOT, ADD, SUB, LSL, LSR, INC, DEC})
        else $error("decode issued a word with an illegal opcode");

endmodule

/* design/cpuPkg.sv */
// shared types of the pipelined core; field widths follow cpu_config.svh
package cpuPkg;

    `include "cpu_config.svh"

    typedef logic [`CPU_DATA_WIDTH-1:0]         data_t;   // one data byte
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0]  regIdx_t; // register number
    typedef logic [`CPU_INSTR_WIDTH-1:0]        instr_t;  // raw instruction word

    typedef struct packed {
        logic zero;      // result is zero
        logic carry;     // carry out, borrow or shifted-out bit
        logic negative;  // result msb
        logic overflow;  // signed overflow, arithmetic only
    } flags_t;

    // reference numbering, holes are illegal
    typedef enum logic [3:0] {
        LDI = 4'h1,
        MOV = 4'h3,
        AND = 4'h4,
        OR  = 4'h5,
        NOT = 4'h6,
        ADD = 4'h7,
        SUB = 4'h8,
        LSL = 4'h9,
        LSR = 4'hA,
        INC = 4'hD,
        DEC = 4'hE
    } opcode_e;

    typedef struct packed {
        logic    valid;     // legal instruction in this slot
        opcode_e op;
        regIdx_t dest;
        data_t   operandA;  // already forwarded
        data_t   operandB;
        data_t   immediate; // low instruction byte for LDI
    } decoded_t;

    typedef struct packed {
        logic    valid;
        regIdx_t dest;
        data_t   data;
        flags_t  flags;
    } exResult_t;

    typedef data_t [`CPU_REG_COUNT-1:0] regFile_t; // whole register file, sent to decode

endpackage

/* design/cpu_config.svh */
// widths are fixed for the 8-bit core and the instruction field positions assume 4 registers
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// register and ALU width
`define CPU_DATA_WIDTH  8

// general registers R0..R3
`define CPU_REG_COUNT   4

// one instruction word, opcode in the top nibble
`define CPU_INSTR_WIDTH 16

// zero, carry, negative, overflow
`define CPU_FLAG_WIDTH  4

`endif
